// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) bench/tb_program.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_program.svh ====
// test program: rv32i instruction words loaded into the testbench instruction memory.
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 35;
localparam rv32_pkg::word_t END_PC = 32'h0000_0088; // final self loop.

localparam rv32_pkg::word_t program_words [PROG_LEN] = '{
  32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h40208233, // addi x1 5, addi x2 -3, add, sub.
  32'h0020C2B3, 32'h00109333, 32'h401153B3, 32'h00112433, // xor, sll, sra, slt.
  32'h001134B3, 32'h40215513, 32'h01C15593, 32'h0F017613, // sltu, srai, srli, andi.
  32'h1000E693, 32'h00012713, 32'hFFF0B793, 32'h00708013, // ori, slti, sltiu, addi to x0.
  32'h12345837, 32'h00001897, 32'h04000913, 32'h01092223, // lui, auipc, base 0x40, sw.
  32'h00492983, 32'h00300A13, 32'hFFFA0A13, 32'hFE0A1EE3, // lw, loop count, decrement, bne back.
  32'h00000463, 32'h00100A93, 32'h00115463, 32'h00200B13, // beq forward taken, skipped, bge, addi.
  32'hFE20FEE3, 32'h008000EF, 32'h00900A93, 32'h00D08BE7, // bgeu back not taken, jal, skipped, jalr.
  32'h00900A93, 32'h013B8C33, 32'h0000006F                // skipped, add, jal x0 0.
};

`endif

// ==== bench/tb_core.sv ====
// core testbench: instruction memory, data RAM with random busy, reference model and checker.
module tb_core;

  `include "tb_program.svh"

  localparam rv32_pkg::word_t RESET_PC = 32'h0000_0000;

  logic                CLK;
  logic                rst;
  rv32_pkg::word_t     imem_addr;
  rv32_pkg::word_t     imem_data;
  logic                dmem_ren;
  logic                dmem_wen;
  rv32_pkg::word_t     dmem_addr;
  rv32_pkg::word_t     dmem_wdata;
  rv32_pkg::word_t     dmem_rdata;
  logic                dmem_busy;
  logic                retire_valid;
  rv32_pkg::retire_t   retire;

  rv32_pkg::word_t imem [64];
  rv32_pkg::word_t ram [64];      // holds words in bus byte order.
  rv32_pkg::word_t ref_regs [32];
  rv32_pkg::word_t ref_mem [64];  // architectural byte order.
  rv32_pkg::word_t ref_pc;
  rv32_pkg::word_t ref_wdata;     // expected store data on the bus.
  rv32_pkg::word_t ref_addr;      // expected data bus address.
  logic            ref_is_store;
  logic            ref_is_load;
  int              mismatches;
  int              failures;
  int              retired;
  int              left;          // busy cycles still owed to this access.
  logic            armed;         // current access already drew its busy count.
  logic            done;
  integer          seed;

  core_top #(.reset_pc(RESET_PC)) uut (
    .CLK          (CLK),
    .rst          (rst),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  assign imem_data  = imem[imem_addr[7:2]]; // combinational fetch.
  assign dmem_rdata = ram[dmem_addr[7:2]];

  function automatic rv32_pkg::word_t swap_bytes(input rv32_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // steps the architectural model by one instruction and returns the expected retirement.
  function automatic rv32_pkg::retire_t ref_step();
    rv32_pkg::retire_t exp;
    rv32_pkg::word_t   ins;
    rv32_pkg::word_t   a;
    rv32_pkg::word_t   b;
    rv32_pkg::word_t   opb;
    rv32_pkg::word_t   val;
    rv32_pkg::word_t   nxt;
    rv32_pkg::word_t   imm_i;
    rv32_pkg::word_t   imm_s;
    rv32_pkg::word_t   imm_b;
    rv32_pkg::word_t   imm_j;
    rv32_pkg::word_t   imm_u;
    rv32_pkg::word_t   ea;
    logic [4:0]        rd;
    logic [2:0]        f3;
    logic              wr;
    logic              cond;
    ins   = imem[ref_pc[7:2]];
    rd    = ins[11:7];
    f3    = ins[14:12];
    a     = ref_regs[ins[19:15]];
    b     = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    nxt   = ref_pc + 32'd4;
    wr    = 1'b0;
    val   = '0;
    cond  = 1'b0;
    ref_is_store = 1'b0;
    ref_is_load  = 1'b0;
    case (ins[6:0])
      7'h37: begin
        wr  = 1'b1;
        val = imm_u;
      end
      7'h17: begin
        wr  = 1'b1;
        val = ref_pc + imm_u;
      end
      7'h6F: begin
        wr  = 1'b1;
        val = ref_pc + 32'd4;
        nxt = ref_pc + imm_j;
      end
      7'h67: begin
        wr  = 1'b1;
        val = ref_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1; // bit 0 dropped.
      end
      7'h63: begin
        case (f3)
          3'd0:    cond = a == b;
          3'd1:    cond = a != b;
          3'd4:    cond = $signed(a) < $signed(b);
          3'd5:    cond = $signed(a) >= $signed(b);
          3'd6:    cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) begin
          nxt = ref_pc + imm_b;
        end
      end
      7'h03: begin
        wr          = 1'b1;
        ea          = a + imm_i;
        val         = ref_mem[ea[7:2]];
        ref_addr    = ea;
        ref_is_load = 1'b1;
      end
      7'h23: begin
        ea = a + imm_s;
        ref_mem[ea[7:2]] = b;
        ref_wdata    = swap_bytes(b);
        ref_addr     = ea;
        ref_is_store = 1'b1;
      end
      7'h13, 7'h33: begin
        wr  = 1'b1;
        opb = (ins[6:0] == 7'h13) ? imm_i : b;
        case (f3)
          3'd0:    val = (ins[5] && ins[30]) ? a - opb : a + opb; // sub only in register form.
          3'd1:    val = a << opb[4:0];
          3'd2:    val = {31'd0, $signed(a) < $signed(opb)};
          3'd3:    val = {31'd0, a < opb};
          3'd4:    val = a ^ opb;
          3'd5:    val = ins[30] ? $unsigned($signed(a) >>> opb[4:0]) : a >> opb[4:0];
          3'd6:    val = a | opb;
          default: val = a & opb;
        endcase
      end
      default: ;
    endcase
    exp.pc   = ref_pc;
    exp.rd   = wr ? rd : 5'd0;
    exp.data = (wr && rd != 5'd0) ? val : '0;
    if (wr && rd != 5'd0) begin
      ref_regs[rd] = val;
    end
    ref_pc = nxt;
    return exp;
  endfunction

  task automatic check(input string name, input rv32_pkg::word_t got, input rv32_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // data RAM write and access completion on the falling edge.
  always @(negedge CLK) begin
    if (!rst && (dmem_ren || dmem_wen) && !dmem_busy) begin
      if (dmem_wen) begin
        ram[dmem_addr[7:2]] = dmem_wdata;
      end
      armed = 1'b0; // access commits on the next edge.
    end
  end

  // busy driver holds each access 0 to 2 cycles.
  always @(posedge CLK) begin
    #2;
    if (rst) begin
      dmem_busy = 1'b0;
      left      = 0;
      armed     = 1'b0;
    end else begin
      if ((dmem_ren || dmem_wen) && !armed) begin
        left  = $unsigned($random(seed)) % 3;
        armed = 1'b1;
      end else if (left > 0) begin
        left = left - 1;
      end
      dmem_busy = (dmem_ren || dmem_wen) && left > 0;
    end
  end

  // compare process steps the model once per retirement.
  always @(negedge CLK) begin
    rv32_pkg::retire_t exp;
    if (!rst && retire_valid && !done) begin
      exp = ref_step();
      check("retire.pc", retire.pc, exp.pc);
      check("retire.rd", {27'd0, retire.rd}, {27'd0, exp.rd});
      check("retire.data", retire.data, exp.data);
      check("dmem_ren", {31'd0, dmem_ren}, {31'd0, ref_is_load});
      check("dmem_wen", {31'd0, dmem_wen}, {31'd0, ref_is_store});
      if (ref_is_load || ref_is_store) begin
        check("dmem_addr", dmem_addr, ref_addr);
      end
      if (ref_is_store) begin
        check("dmem_wdata", dmem_wdata, ref_wdata);
      end
      retired++;
      if (exp.pc == END_PC) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    int cycles;
    seed       = 32'h6666;
    rst        = 1'b1;
    dmem_busy  = 1'b0;
    mismatches = 0;
    failures   = 0;
    retired    = 0;
    left       = 0;
    armed      = 1'b0;
    done       = 1'b0;
    ref_pc     = RESET_PC;
    for (int i = 0; i < 64; i++) begin
      imem[i]    = rv32_pkg::word_t'(i) << 7; // opcode zero decodes as illegal.
      ram[i]     = 32'hC3A5_0000 ^ rv32_pkg::word_t'(i * 32'h0101);
      ref_mem[i] = swap_bytes(32'hC3A5_0000 ^ rv32_pkg::word_t'(i * 32'h0101));
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = program_words[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (10) @(posedge CLK);
    #2;
    rst = 1'b0;
    @(negedge CLK);
    if (retire_valid !== 1'b0 || dmem_ren !== 1'b0 || dmem_wen !== 1'b0) begin
      $display("outputs not idle in the first cycle after reset");
      failures++;
    end
    cycles = 0;
    while (!done && cycles < 2000) begin
      @(posedge CLK);
      cycles++;
    end
    if (!done) begin
      $display("timeout waiting for the final retirement after %0d cycles", cycles);
      failures++;
    end
    $display("retired=%0d mismatches=%0d other_errors=%0d", retired, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/alu.sv ====
// alu: rv32i add, sub, logic, shift and set-less-than.
module alu (
  input  rv32_pkg::alu_op_e op,
  input  rv32_pkg::word_t   a,
  input  rv32_pkg::word_t   b,
  output rv32_pkg::word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // only low five bits shift.

  always_comb begin
    case (op)
      rv32_pkg::ALU_ADD:  y = a + b;
      rv32_pkg::ALU_SUB:  y = a - b;
      rv32_pkg::ALU_SLL:  y = a << shamt;
      rv32_pkg::ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
      rv32_pkg::ALU_SLTU: y = {31'd0, a < b};
      rv32_pkg::ALU_XOR:  y = a ^ b;
      rv32_pkg::ALU_SRL:  y = a >> shamt;
      rv32_pkg::ALU_SRA:  y = $unsigned($signed(a) >>> shamt); // sign fill.
      rv32_pkg::ALU_OR:   y = a | b;
      rv32_pkg::ALU_AND:  y = a & b;
      default:            y = a + b;
    endcase
  end

endmodule

// ==== hdl/branch_res.sv ====
// branch resolution: evaluates the branch condition and forms the branch target.
module branch_res (
  input  rv32_pkg::ctrl_t ctrl,
  input  rv32_pkg::word_t pc,
  input  rv32_pkg::word_t rs1_data,
  input  rv32_pkg::word_t rs2_data,
  output logic            taken,
  output rv32_pkg::word_t target
);

  logic cond;

  always_comb begin
    case (ctrl.branch_type)
      rv32_pkg::BEQ:  cond = rs1_data == rs2_data;
      rv32_pkg::BNE:  cond = rs1_data != rs2_data;
      rv32_pkg::BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
      rv32_pkg::BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
      rv32_pkg::BLTU: cond = rs1_data < rs2_data;
      rv32_pkg::BGEU: cond = rs1_data >= rs2_data;
      default:        cond = 1'b0;
    endcase
  end

  assign taken  = ctrl.is_branch && cond; // low for anything that is not a branch.
  assign target = pc + ctrl.imm_sb;

endmodule

// ==== hdl/control_unit.sv ====
// control unit: decodes an rv32i word into control flags and sign-extended immediates.
module control_unit (
  input  rv32_pkg::word_t instr,
  output rv32_pkg::ctrl_t ctrl
);

  rv32_pkg::opcode_e op;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              alt;    // funct7 marks sub / sra.
  logic              f7_ok;  // funct7 legal for a register op.
  logic              sh_ok;  // funct7 legal for a shift immediate.

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign alt    = funct7 == 7'b0100000;
  assign f7_ok  = (funct7 == 7'b0000000) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
  assign sh_ok  = (funct7 == 7'b0000000) || (alt && funct3 == 3'b101);

  // funct3 to alu op, alt picks the second flavour.
  function automatic rv32_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic a);
    rv32_pkg::alu_op_e res;
    case (f3)
      3'b000:  res = a ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      3'b001:  res = rv32_pkg::ALU_SLL;
      3'b010:  res = rv32_pkg::ALU_SLT;
      3'b011:  res = rv32_pkg::ALU_SLTU;
      3'b100:  res = rv32_pkg::ALU_XOR;
      3'b101:  res = a ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      3'b110:  res = rv32_pkg::ALU_OR;
      default: res = rv32_pkg::ALU_AND;
    endcase
    return res;
  endfunction

  always_comb begin
    case (instr[6:0])
      rv32_pkg::OPC_LUI, rv32_pkg::OPC_AUIPC, rv32_pkg::OPC_JAL:
        op = rv32_pkg::opcode_e'(instr[6:0]);
      rv32_pkg::OPC_JALR:   op = (funct3 == 3'b000) ? rv32_pkg::OPC_JALR : rv32_pkg::OPC_ILLEGAL;
      rv32_pkg::OPC_BRANCH: op = (funct3[2:1] == 2'b01) ? rv32_pkg::OPC_ILLEGAL : rv32_pkg::OPC_BRANCH;
      rv32_pkg::OPC_LOAD:   op = (funct3 == 3'b010) ? rv32_pkg::OPC_LOAD : rv32_pkg::OPC_ILLEGAL;
      rv32_pkg::OPC_STORE:  op = (funct3 == 3'b010) ? rv32_pkg::OPC_STORE : rv32_pkg::OPC_ILLEGAL;
      rv32_pkg::OPC_OP_IMM: op = (funct3[1:0] != 2'b01 || sh_ok) ? rv32_pkg::OPC_OP_IMM
                                                                  : rv32_pkg::OPC_ILLEGAL;
      rv32_pkg::OPC_OP:     op = f7_ok ? rv32_pkg::OPC_OP : rv32_pkg::OPC_ILLEGAL;
      default:              op = rv32_pkg::OPC_ILLEGAL; // fence, system, sub-word access.
    endcase
  end

  always_comb begin
    ctrl.alu_op      = rv32_pkg::ALU_ADD;
    ctrl.branch_type = rv32_pkg::branch_type_e'(funct3);
    ctrl.a_sel       = rv32_pkg::A_RS1;
    ctrl.b_sel       = rv32_pkg::B_RS2;
    ctrl.w_sel       = rv32_pkg::W_ALU;
    ctrl.rf_wen      = 1'b0; // illegal falls through with no side effect.
    ctrl.dren        = 1'b0;
    ctrl.dwen        = 1'b0;
    ctrl.is_branch   = 1'b0;
    ctrl.is_jump     = 1'b0;
    ctrl.j_sel       = 1'b0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];
    ctrl.imm_i       = {{20{instr[31]}}, instr[31:20]}; // also carries shamt.
    ctrl.imm_s       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_sb      = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_uj      = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u       = {instr[31:12], 12'h000};
    case (op)
      rv32_pkg::OPC_LUI: begin
        ctrl.rf_wen = 1'b1;
        ctrl.w_sel  = rv32_pkg::W_IMM_U;
      end
      rv32_pkg::OPC_AUIPC: begin
        ctrl.rf_wen = 1'b1;
        ctrl.a_sel  = rv32_pkg::A_PC;
        ctrl.b_sel  = rv32_pkg::B_IMM_U; // pc plus upper immediate.
      end
      rv32_pkg::OPC_JAL, rv32_pkg::OPC_JALR: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.j_sel   = op == rv32_pkg::OPC_JAL;
        ctrl.w_sel   = rv32_pkg::W_PC4; // link value.
      end
      rv32_pkg::OPC_BRANCH: ctrl.is_branch = 1'b1;
      rv32_pkg::OPC_LOAD: begin
        ctrl.rf_wen = 1'b1;
        ctrl.dren   = 1'b1;
        ctrl.b_sel  = rv32_pkg::B_IMM_I;
        ctrl.w_sel  = rv32_pkg::W_LOAD;
      end
      rv32_pkg::OPC_STORE: begin
        ctrl.dwen  = 1'b1;
        ctrl.b_sel = rv32_pkg::B_IMM_S;
      end
      rv32_pkg::OPC_OP_IMM: begin
        ctrl.rf_wen = 1'b1;
        ctrl.b_sel  = rv32_pkg::B_IMM_I;
        ctrl.alu_op = alu_decode(funct3, alt && funct3 == 3'b101); // no subi.
      end
      rv32_pkg::OPC_OP: begin
        ctrl.rf_wen = 1'b1;
        ctrl.alu_op = alu_decode(funct3, alt);
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/core_top.sv ====
// core top: two-stage rv32i core, fetch feeding execute, with instruction and data ports.
module core_top #(
  parameter rv32_pkg::word_t reset_pc = '0
) (
  input  logic              CLK,
  input  logic              rst,
  output rv32_pkg::word_t   imem_addr,
  input  rv32_pkg::word_t   imem_data,
  output logic              dmem_ren,
  output logic              dmem_wen,
  output rv32_pkg::word_t   dmem_addr,
  output rv32_pkg::word_t   dmem_wdata,
  input  rv32_pkg::word_t   dmem_rdata,
  input  logic              dmem_busy,
  output logic              retire_valid,
  output rv32_pkg::retire_t retire
);

  rv32_pkg::fetch_exec_t fe;    // fetch to execute slot.
  rv32_pkg::redirect_t   redir; // execute back to fetch.
  logic                  stall;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .CLK       (CLK),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .redir     (redir),
    .stall     (stall),
    .fe        (fe)
  );

  execute_stage u_exec (
    .CLK          (CLK),
    .rst          (rst),
    .fe           (fe),
    .redir        (redir),
    .stall        (stall),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// ==== hdl/execute_stage.sv ====
// execute stage: decode, register read, alu, branch and jump resolve, data bus, write-back.
module execute_stage (
  input  logic                  CLK,
  input  logic                  rst,
  input  rv32_pkg::fetch_exec_t fe,
  output rv32_pkg::redirect_t   redir,
  output logic                  stall,
  output logic                  dmem_ren,
  output logic                  dmem_wen,
  output rv32_pkg::word_t       dmem_addr,
  output rv32_pkg::word_t       dmem_wdata,
  input  rv32_pkg::word_t       dmem_rdata,
  input  logic                  dmem_busy,
  output logic                  retire_valid,
  output rv32_pkg::retire_t     retire
);

  rv32_pkg::ctrl_t ctrl;
  rv32_pkg::word_t rs1_data;
  rv32_pkg::word_t rs2_data;
  rv32_pkg::word_t alu_a;
  rv32_pkg::word_t alu_b;
  rv32_pkg::word_t alu_y;
  rv32_pkg::word_t br_target;
  rv32_pkg::word_t jump_target;
  rv32_pkg::word_t load_data;
  rv32_pkg::word_t wdata;
  logic            br_taken;
  logic            mispredict;
  logic            commit;

  // memory side is the other byte order.
  function automatic rv32_pkg::word_t byte_swap(input rv32_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  control_unit u_cu (.instr(fe.instr), .ctrl(ctrl));

  reg_file u_rf (
    .CLK      (CLK),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wen      (commit && ctrl.rf_wen), // held off while busy.
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

  branch_res u_br (
    .ctrl     (ctrl),
    .pc       (fe.pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (br_taken),
    .target   (br_target)
  );

  assign alu_a = (ctrl.a_sel == rv32_pkg::A_PC) ? fe.pc : rs1_data;

  always_comb begin
    case (ctrl.b_sel)
      rv32_pkg::B_IMM_I: alu_b = ctrl.imm_i;
      rv32_pkg::B_IMM_S: alu_b = ctrl.imm_s;
      rv32_pkg::B_IMM_U: alu_b = ctrl.imm_u; // auipc.
      default:           alu_b = rs2_data;
    endcase
  end

  assign load_data = byte_swap(dmem_rdata);

  always_comb begin
    case (ctrl.w_sel)
      rv32_pkg::W_LOAD:  wdata = load_data;
      rv32_pkg::W_PC4:   wdata = fe.pc4;
      rv32_pkg::W_IMM_U: wdata = ctrl.imm_u;
      default:           wdata = alu_y;
    endcase
  end

  // jal is pc relative, jalr drops bit 0.
  assign jump_target = ctrl.j_sel ? fe.pc + ctrl.imm_uj
                                  : (rs1_data + ctrl.imm_i) & ~32'd1;

  assign mispredict  = fe.prediction ^ br_taken; // jumps always guessed not taken.
  assign redir.valid = fe.valid && (ctrl.is_jump || mispredict);
  assign redir.addr  = ctrl.is_jump ? jump_target : (br_taken ? br_target : fe.pc4);

  assign dmem_ren   = fe.valid && ctrl.dren; // levels held until busy drops.
  assign dmem_wen   = fe.valid && ctrl.dwen;
  assign dmem_addr  = alu_y;
  assign dmem_wdata = byte_swap(rs2_data);
  assign stall      = (dmem_ren || dmem_wen) && dmem_busy;

  assign commit       = fe.valid && !stall;
  assign retire_valid = commit;
  assign retire.pc    = fe.pc;
  assign retire.rd    = ctrl.rf_wen ? ctrl.rd : 5'd0; // rd 0 means no write.
  assign retire.data  = (ctrl.rf_wen && ctrl.rd != 5'd0) ? wdata : '0;

  a_mem_excl: assert property (@(posedge CLK) disable iff (rst) !(dmem_ren && dmem_wen))
    else $error("load and store requested together");

  // only memory ops stall and they never redirect, so fetch never sees both.
  a_redir_no_stall: assert property (@(posedge CLK) disable iff (rst) !(redir.valid && stall))
    else $error("redirect raised during stall");

endmodule

// ==== hdl/fetch_stage.sv ====
// fetch stage: pc register, static backward-taken prediction, fetch to execute register.
module fetch_stage #(
  parameter rv32_pkg::word_t reset_pc = '0
) (
  input  logic                  CLK,
  input  logic                  rst,
  output rv32_pkg::word_t       imem_addr,
  input  rv32_pkg::word_t       imem_data,
  input  rv32_pkg::redirect_t   redir,
  input  logic                  stall,
  output rv32_pkg::fetch_exec_t fe
);

  rv32_pkg::word_t pc;          // address being fetched this cycle.
  rv32_pkg::word_t pc4;
  rv32_pkg::word_t imm_sb;      // predecoded branch offset.
  rv32_pkg::word_t pred_target;
  rv32_pkg::word_t pc_next;
  logic            is_branch;
  logic            predict;

  assign imem_addr   = pc; // instruction read is combinational.
  assign pc4         = pc + 32'd4;
  assign is_branch   = imem_data[6:0] == rv32_pkg::OPC_BRANCH;
  assign imm_sb      = {{20{imem_data[31]}}, imem_data[7], imem_data[30:25],
                        imem_data[11:8], 1'b0};
  assign predict     = is_branch && imem_data[31]; // negative offset means loop, guess taken.
  assign pred_target = pc + imm_sb;

  always_comb begin
    if (redir.valid) begin
      pc_next = redir.addr; // execute overrides any guess.
    end else if (predict) begin
      pc_next = pred_target;
    end else begin
      pc_next = pc4;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc       <= reset_pc;
      fe.valid <= 1'b0;
    end else if (!stall) begin
      pc            <= pc_next;
      fe.valid      <= !redir.valid; // wrong-path word becomes a bubble.
      fe.pc         <= pc;
      fe.pc4        <= pc4;
      fe.instr      <= imem_data;
      fe.prediction <= predict;
    end
  end

  // redirect targets from execute must keep the fetch address aligned.
  a_imem_aligned: assert property (@(posedge CLK) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("fetch address %h not word aligned", imem_addr);

endmodule

// ==== hdl/reg_file.sv ====
// register file: 32 x 32 bits, two asynchronous reads and one synchronous write.
module reg_file (
  input  logic            CLK,
  input  logic            rst,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            wen,
  input  rv32_pkg::word_t wdata,
  output rv32_pkg::word_t rs1_data,
  output rv32_pkg::word_t rs2_data
);

  rv32_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata; // x0 writes dropped.
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 hard zero.
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hdl/rv32_pkg.sv ====
// rv32 core package: shared word type, decode enums and pipeline structs.
package rv32_pkg;

  typedef logic [31:0] word_t; // data and address word.

  typedef enum logic [6:0] {
    OPC_ILLEGAL = 7'b0000000, // anything we do not support.
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_BRANCH  = 7'b1100011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_OP      = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // encodings are funct3 of the branch word.
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_e;

  typedef enum logic [1:0] {A_RS1, A_PC} a_sel_e; // alu port a.
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_e; // alu port b.
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_e; // write-back source.

  typedef struct packed {
    logic  valid;      // slot holds a live instruction.
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction; // fetch guessed taken.
  } fetch_exec_t;

  typedef struct packed {
    alu_op_e      alu_op;
    branch_type_e branch_type;
    a_sel_e       a_sel;
    b_sel_e       b_sel;
    w_sel_e       w_sel;
    logic         rf_wen;
    logic         dren;
    logic         dwen;
    logic         is_branch;
    logic         is_jump;
    logic         j_sel;     // 1 for jal, 0 for jalr.
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [4:0]   rd;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_sb;
    word_t        imm_uj;
    word_t        imm_u;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
  } redirect_t;

  typedef struct packed {
    word_t      pc;
    logic [4:0] rd;
    word_t      data;
  } retire_t;

endpackage

// ==== vlog.f ====
+incdir+bench
hdl/rv32_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_res.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/core_top.sv
bench/tb_core.sv
